//--- bench/pdp8_core_tb.sv
// ----------------------------------------
// Programs enter through the panel. Link is never cleared
// between tests, so its expected value is carried along.
// ----------------------------------------
`timescale 1ns/1ps
`default_nettype none

module pdp8_core_tb
  import pdp8_pkg::*;
();

  localparam int WAIT_LIMIT  = 300;
  localparam int CMD_LOAD_PC = 0;
  localparam int CMD_LOAD_AC = 1;
  localparam int CMD_DEPOSIT = 2;
  localparam int CMD_STEP    = 3;

  logic   clock;
  logic   resetN;
  logic   run;
  logic   step;
  logic   load_pc;
  logic   load_ac;
  logic   deposit;
  word_t  switch_reg;
  word_t  ac;
  word_t  pc;
  logic   link;
  logic   halt;
  logic   idle;

  integer seed;
  int     errors;
  int     errors_at_start;
  int     tests;
  logic   exp_link;
  logic   halt_seen;
  word_t  a_val;
  word_t  b_val;
  word_t  c_val;
  word_t  exp_ac;

  tb_clock_gen tb_clock_gen_inst (
    .clock  (clock),
    .resetN (resetN)
  );

  pdp8_core pdp8_core_inst (
    .clock      (clock),
    .resetN     (resetN),
    .run        (run),
    .step       (step),
    .load_pc    (load_pc),
    .load_ac    (load_ac),
    .deposit    (deposit),
    .switch_reg (switch_reg),
    .ac         (ac),
    .pc         (pc),
    .link       (link),
    .halt       (halt),
    .idle       (idle)
  );

  function automatic word_t rand_word();
    logic [31:0] r;
    r = $random(seed);
    return r[11:0];
  endfunction

  // Two's complement add; a carry out complements the link
  function automatic word_t model_tad(input word_t acc, input word_t operand);
    logic [12:0] sum;
    sum = {1'b0, acc} + {1'b0, operand};
    if (sum[12]) exp_link = ~exp_link;
    return sum[11:0];
  endfunction

  task automatic check_word(input string name, input word_t expected, input word_t actual);
    assert (actual === expected)
      else begin
        $display("mismatch %s expected %o actual %o", name, expected, actual);
        errors++;
      end
  endtask

  task automatic expect_state(input string name, input word_t want_ac, input word_t want_pc);
    check_word({name, " ac"}, want_ac, ac);
    check_word({name, " link"}, {11'd0, exp_link}, {11'd0, link});
    check_word({name, " pc"}, want_pc, pc);
  endtask

  task automatic wait_signal(input bit use_halt, input logic level, input string what);
    int cycles;
    cycles = 0;
    while (((use_halt ? halt : idle) !== level) && cycles < WAIT_LIMIT) begin
      @(negedge clock);
      cycles++;
    end
    if ((use_halt ? halt : idle) !== level) begin
      $display("timeout waiting for %s", what);
      $display("tests failed");
      $finish;
    end
  endtask

  // Level held until the FSM leaves idle, then released
  task automatic panel_command(input int cmd, input word_t value);
    switch_reg = value;
    load_pc = (cmd == CMD_LOAD_PC);
    load_ac = (cmd == CMD_LOAD_AC);
    deposit = (cmd == CMD_DEPOSIT);
    step    = (cmd == CMD_STEP);
    wait_signal(1'b0, 1'b0, "panel command to start");
    load_pc = 1'b0;
    load_ac = 1'b0;
    deposit = 1'b0;
    step    = 1'b0;
    wait_signal(1'b0, 1'b1, "panel command to end");
  endtask

  task automatic load_block(input addr_t base, input word_t w0, input word_t w1,
                            input word_t w2, input word_t w3, input word_t w4,
                            input word_t w5);
    panel_command(CMD_LOAD_PC, base);
    panel_command(CMD_DEPOSIT, w0);
    panel_command(CMD_DEPOSIT, w1);
    panel_command(CMD_DEPOSIT, w2);
    panel_command(CMD_DEPOSIT, w3);
    panel_command(CMD_DEPOSIT, w4);
    panel_command(CMD_DEPOSIT, w5);
  endtask

  task automatic run_to_halt(input string name);
    run = 1'b1;
    wait_signal(1'b1, 1'b1, {name, " halt"});
    run = 1'b0;
    wait_signal(1'b1, 1'b0, {name, " halt to clear"});
    wait_signal(1'b0, 1'b1, {name, " idle"});
  endtask

  task automatic run_from(input addr_t start, input string name);
    panel_command(CMD_LOAD_AC, 12'o0000);
    panel_command(CMD_LOAD_PC, start);
    run_to_halt(name);
  endtask

  task automatic finish_test(input string name);
    tests++;
    if (errors == errors_at_start) $display("%s: ok", name);
    else $display("%s: %0d errors", name, errors - errors_at_start);
    errors_at_start = errors;
  endtask

  task automatic isz_case(input string name, input word_t value, input word_t marker);
    load_block(12'o0050, value, marker, 12'o0000, 12'o0000, 12'o0000, 12'o0000);
    load_block(12'o0200, 12'o2050, 12'o1051, 12'o1050, HLT_WORD, HLT_WORD, HLT_WORD);
    if (value == 12'o7777) exp_ac = 12'o0000;  // Marker skipped, word wrapped to 0
    else exp_ac = model_tad(model_tad(12'o0000, marker), value + 12'd1);
    run_from(12'o0200, name);
    expect_state(name, exp_ac, 12'o0204);
    finish_test(name);
  endtask

  // HALT lasts a single cycle before the return to idle
  always @(negedge clock) begin
    if (resetN !== 1'b1) begin
      halt_seen = 1'b0;
    end else begin
      assert (!(halt && halt_seen))
        else begin
          $display("halt stayed high for more than one cycle");
          errors++;
        end
      halt_seen = halt;
    end
  end

  initial begin
    seed = 32'h4e5b;
    errors = 0;
    errors_at_start = 0;
    tests = 0;
    exp_link = 1'b0;
    run = 1'b0;
    step = 1'b0;
    load_pc = 1'b0;
    load_ac = 1'b0;
    deposit = 1'b0;
    switch_reg = '0;

    wait_signal(1'b0, 1'b1, "idle after reset");
    check_word("reset halt", 12'd0, {11'd0, halt});
    check_word("reset ac", 12'd0, ac);
    check_word("reset link", 12'd0, {11'd0, link});
    finish_test("reset");

    a_val = rand_word();
    panel_command(CMD_LOAD_AC, a_val);
    check_word("panel ac", a_val, ac);
    b_val = 12'o0300 | (rand_word() & 12'o0077);
    load_block(b_val, 12'o1111, 12'o2222, 12'o3333, 12'o4444, 12'o5555, 12'o6666);
    check_word("panel pc", b_val + 12'd6, pc);
    finish_test("panel");

    // TAD A, TAD B, AND C, DCA D, TAD D, HLT
    a_val = rand_word();
    b_val = rand_word();
    c_val = rand_word();
    load_block(12'o0040, a_val, b_val, c_val, 12'o0000, 12'o0000, 12'o0000);
    load_block(12'o0200, 12'o1040, 12'o1041, 12'o0042, 12'o3043, 12'o1043, HLT_WORD);
    exp_ac = model_tad(model_tad(12'o0000, a_val), b_val) & c_val;
    exp_ac = model_tad(12'o0000, exp_ac);
    run_from(12'o0200, "arith");
    expect_state("arith", exp_ac, 12'o0206);
    finish_test("arith");

    a_val = rand_word() | 12'o0001;
    isz_case("isz skip", 12'o7777, a_val);
    a_val = rand_word() | 12'o0001;
    b_val = rand_word() & 12'o7776;
    isz_case("isz no skip", b_val, a_val);

    a_val = rand_word();
    b_val = rand_word();
    load_block(12'o0070, a_val, 12'o0000, b_val, 12'o0000, 12'o0000, 12'o0000);
    panel_command(CMD_LOAD_PC, 12'o0260);
    panel_command(CMD_DEPOSIT, 12'o0070);  // Current-page pointer to A
    panel_command(CMD_LOAD_PC, 12'o0010);
    panel_command(CMD_DEPOSIT, 12'o0071);  // Incremented before use
    load_block(12'o0200, 12'o1660, HLT_WORD, 12'o1410, HLT_WORD, 12'o1010, HLT_WORD);
    exp_ac = model_tad(12'o0000, a_val);
    run_from(12'o0200, "indirect");
    expect_state("indirect", exp_ac, 12'o0202);
    exp_ac = model_tad(exp_ac, b_val);
    run_to_halt("auto index");
    expect_state("auto index", exp_ac, 12'o0204);
    exp_ac = model_tad(exp_ac, 12'o0072);
    run_to_halt("auto pointer");
    expect_state("auto pointer", exp_ac, 12'o0206);
    finish_test("indirect");

    // JMS to 0220, TAD marker, JMP I 0220 back to HLT at 0201
    c_val = rand_word();
    panel_command(CMD_LOAD_PC, 12'o0062);
    panel_command(CMD_DEPOSIT, c_val);
    load_block(12'o0220, 12'o0000, 12'o1062, 12'o5620, HLT_WORD, HLT_WORD, HLT_WORD);
    load_block(12'o0200, 12'o4220, HLT_WORD, 12'o1220, HLT_WORD, HLT_WORD, HLT_WORD);
    exp_ac = model_tad(12'o0000, c_val);
    run_from(12'o0200, "jms jmp");
    expect_state("jms jmp", exp_ac, 12'o0202);
    exp_ac = model_tad(exp_ac, 12'o0201);  // Stored return address
    panel_command(CMD_STEP, 12'o0000);
    expect_state("single step", exp_ac, 12'o0203);
    run_to_halt("return address");
    expect_state("return address", exp_ac, 12'o0204);
    finish_test("jms jmp");

    $display("%0d tests run, %0d checks wrong", tests, errors);
    if (errors == 0) begin
      $display("all tests passed");
    end else begin
      $display("tests failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- bench/tb_clock_gen.sv
// ----------------------------------------
// 10 ns clock, reset low for the first 3 cycles
// ----------------------------------------
`timescale 1ns/1ps
`default_nettype none

module tb_clock_gen (
  output logic clock,
  output logic resetN
);

  initial begin
    clock = 1'b0;
    forever #5 clock = ~clock;
  end

  initial begin
    resetN = 1'b0;
    repeat (3) @(posedge clock);
    @(negedge clock);
    resetN = 1'b1;  // Released away from the active edge
  end

endmodule

`default_nettype wire

//--- hw/pdp8_core.sv
// ----------------------------------------
// Core top. Panel inputs are levels and are only
// sampled while the sequencer is idle.
// ----------------------------------------
`timescale 1ns/1ps
`default_nettype none

module pdp8_core
  import pdp8_pkg::*;
(
  input  logic  clock,
  input  logic  resetN,
  input  logic  run,
  input  logic  step,
  input  logic  load_pc,
  input  logic  load_ac,
  input  logic  deposit,
  input  word_t switch_reg,
  output word_t ac,
  output word_t pc,
  output logic  link,
  output logic  halt,
  output logic  idle
);

  ctrl_t      ctrl;
  dp_status_t status;
  mem_req_t   mem_req;
  word_t      rdata;
  logic       mem_finished;

  pdp8_sequencer pdp8_sequencer_inst (
    .clock        (clock),
    .resetN       (resetN),
    .run          (run),
    .step         (step),
    .load_pc      (load_pc),
    .load_ac      (load_ac),
    .deposit      (deposit),
    .status       (status),
    .mem_finished (mem_finished),
    .ctrl         (ctrl),
    .halt         (halt),
    .idle         (idle)
  );

  pdp8_datapath pdp8_datapath_inst (
    .clock        (clock),
    .resetN       (resetN),
    .ctrl         (ctrl),
    .switch_reg   (switch_reg),
    .rdata        (rdata),
    .mem_finished (mem_finished),
    .mem_req      (mem_req),
    .status       (status),
    .ac           (ac),
    .pc           (pc),
    .link         (link)
  );

  pdp8_memory pdp8_memory_inst (
    .clock        (clock),
    .resetN       (resetN),
    .mem_req      (mem_req),
    .rdata        (rdata),
    .mem_finished (mem_finished)
  );

endmodule

`default_nettype wire

//--- hw/pdp8_datapath.sv
// ----------------------------------------
// Registers under control-word command. Current page is
// taken from the already incremented PC.
// ----------------------------------------
`timescale 1ns/1ps
`default_nettype none

module pdp8_datapath
  import pdp8_pkg::*;
(
  input  logic       clock,
  input  logic       resetN,
  input  ctrl_t      ctrl,
  input  word_t      switch_reg,
  input  word_t      rdata,
  input  logic       mem_finished,
  output mem_req_t   mem_req,
  output dp_status_t status,
  output word_t      ac,
  output word_t      pc,
  output logic       link
);

  word_t ir;
  word_t mb;
  addr_t ea;
  addr_t mem_addr;
  word_t wdata;
  word_t tad_word;
  logic  tad_carry;
  addr_t page_zero_ea;
  addr_t curr_page_ea;

  assign {tad_carry, tad_word} = ac + mb;
  assign page_zero_ea = {5'b0, ir[6:0]};
  assign curr_page_ea = {pc[11:7], ir[6:0]};

  always_ff @(posedge clock or negedge resetN) begin
    if (!resetN) begin
      ac   <= '0;
      link <= 1'b0;
    end else begin
      case (ctrl.ac_op)
        AC_CLEAR: ac <= '0;
        AC_SWREG: ac <= switch_reg;
        AC_AND:   ac <= ac & mb;
        AC_TAD:   ac <= tad_word;
        default:  ac <= ac;
      endcase
      case (ctrl.link_op)
        LK_ZERO: link <= 1'b0;
        LK_TAD:  link <= link ^ tad_carry;  // Carry complements link
        default: link <= link;
      endcase
    end
  end

  always_ff @(posedge clock or negedge resetN) begin
    if (!resetN) begin
      pc <= '0;
      ir <= '0;
    end else begin
      case (ctrl.pc_op)
        PC_P1:   pc <= pc + 1'b1;
        PC_SR:   pc <= switch_reg;
        PC_EA:   pc <= ea;
        PC_EAP1: pc <= ea + 1'b1;
        default: pc <= pc;
      endcase
      if (ctrl.ir_load && mem_finished) begin
        ir <= rdata;
      end
    end
  end

  always_ff @(posedge clock or negedge resetN) begin
    if (!resetN) begin
      ea <= '0;
      mb <= '0;
    end else begin
      case (ctrl.ea_op)
        EA_ZERO: ea <= '0;
        EA_PZ:   ea <= page_zero_ea;
        EA_CP:   ea <= curr_page_ea;
        EA_IND:  ea <= rdata;
        EA_WD:   ea <= wdata;            // Incremented auto-index pointer
        default: ea <= ea;
      endcase
      case (ctrl.mb_op)
        MB_ZERO: mb <= '0;
        MB_RD:   if (mem_finished) mb <= rdata;
        MB_INC:  mb <= mb + 1'b1;
        MB_WD:   mb <= wdata;
        default: mb <= mb;
      endcase
    end
  end

  // Address and write data buffers into the memory
  always_ff @(posedge clock) begin
    case (ctrl.ad_sel)
      AD_PC:   mem_addr <= pc;
      AD_EA:   mem_addr <= ea;
      default: mem_addr <= mem_addr;
    endcase
    case (ctrl.wd_sel)
      WD_SR:   wdata <= switch_reg;
      WD_AC:   wdata <= ac;
      WD_MB:   wdata <= mb;
      WD_PC:   wdata <= pc;
      WD_RDP1: wdata <= rdata + 1'b1;
      default: wdata <= wdata;
    endcase
  end

  assign mem_req.address = mem_addr;
  assign mem_req.wdata   = wdata;
  assign mem_req.read    = ctrl.read_enable;
  assign mem_req.write   = ctrl.write_enable;

  assign status.ir      = ir;
  assign status.ea_auto = (ea >= AUTO_LO) && (ea <= AUTO_HI);
  assign status.mb_zero = (mb == '0);

endmodule

`default_nettype wire

//--- hw/pdp8_memory.sv
// ----------------------------------------
// Word memory, one access per request. Contents
// come up undefined; programs are deposited first.
// ----------------------------------------
`timescale 1ns/1ps
`default_nettype none

module pdp8_memory
  import pdp8_pkg::*;
(
  input  logic     clock,
  input  logic     resetN,
  input  mem_req_t mem_req,
  output word_t    rdata,
  output logic     mem_finished
);

  word_t mem [MEM_DEPTH];
  logic  access;

  // Request still open until finished has been seen
  assign access = (mem_req.read || mem_req.write) && !mem_finished;

  always_ff @(posedge clock) begin
    if (access) begin
      if (mem_req.write) begin
        mem[mem_req.address] <= mem_req.wdata;
      end
      if (mem_req.read) begin
        rdata <= mem[mem_req.address];
      end
    end
  end

  always_ff @(posedge clock or negedge resetN) begin
    if (!resetN) begin
      mem_finished <= 1'b0;
    end else begin
      mem_finished <= access;  // One-cycle pulse
    end
  end

endmodule

`default_nettype wire

//--- hw/pdp8_pkg.sv
// ----------------------------------------
// Shared types for the PDP-8 style core. Only AND..JMP and HLT
// execute; IOT and other operate opcodes are no-ops.
// ----------------------------------------
`default_nettype none

package pdp8_pkg;

  typedef logic [11:0] word_t;
  typedef logic [11:0] addr_t;
  typedef logic [2:0]  opcode_t;

  localparam int      MEM_DEPTH   = 4096;

  localparam opcode_t OP_AND      = 3'd0;
  localparam opcode_t OP_TAD      = 3'd1;
  localparam opcode_t OP_ISZ      = 3'd2;
  localparam opcode_t OP_DCA      = 3'd3;
  localparam opcode_t OP_JMS      = 3'd4;
  localparam opcode_t OP_JMP      = 3'd5;
  localparam opcode_t OP_IOT      = 3'd6;
  localparam opcode_t OP_OPR      = 3'd7;

  localparam word_t   HLT_WORD    = 12'o7402;
  localparam addr_t   AUTO_LO     = 12'd8;  // Auto-index window
  localparam addr_t   AUTO_HI     = 12'd15;
  localparam int      IR_IND_BIT  = 8;
  localparam int      IR_PAGE_BIT = 7;

  typedef enum logic [5:0] {
    REG_INIT, CPU_IDLE,
    FETCH_1, FETCH_2, FETCH_3, DECODE,
    LD_PC_1, LD_AC_1, DEP_1, DEP_2,
    CAL_EA_1, EA_IND_1, EA_IND_2,
    EA_AUT_1, EA_AUT_2, EA_AUT_3, EA_AUT_4, EA_AUT_5,
    AND_1, AND_2, AND_3,
    TAD_1, TAD_2, TAD_3,
    ISZ_1, ISZ_2, ISZ_3, ISZ_4, ISZ_5, ISZ_6,
    DCA_1, DCA_2, DCA_3,
    JMS_1, JMS_2, JMP_1,
    HALT
  } seq_state_t;

  typedef enum logic [2:0] {AC_NC, AC_CLEAR, AC_SWREG, AC_AND, AC_TAD} ac_op_t;
  typedef enum logic [1:0] {LK_NC, LK_ZERO, LK_TAD} link_op_t;
  typedef enum logic [2:0] {PC_NC, PC_P1, PC_SR, PC_EA, PC_EAP1} pc_op_t;
  typedef enum logic [2:0] {EA_NC, EA_ZERO, EA_PZ, EA_CP, EA_IND, EA_WD} ea_op_t;
  typedef enum logic [2:0] {MB_NC, MB_ZERO, MB_RD, MB_INC, MB_WD} mb_op_t;
  typedef enum logic [2:0] {WD_NC, WD_SR, WD_AC, WD_MB, WD_PC, WD_RDP1} wd_sel_t;
  typedef enum logic [1:0] {AD_NC, AD_PC, AD_EA} ad_sel_t;

  typedef struct packed {
    ac_op_t   ac_op;
    link_op_t link_op;
    pc_op_t   pc_op;
    ea_op_t   ea_op;
    mb_op_t   mb_op;
    wd_sel_t  wd_sel;
    ad_sel_t  ad_sel;
    logic     ir_load;
    logic     read_enable;
    logic     write_enable;
  } ctrl_t;

  typedef struct packed {
    addr_t address;
    word_t wdata;
    logic  read;
    logic  write;
  } mem_req_t;

  typedef struct packed {
    word_t ir;
    logic  ea_auto;  // EA inside auto-index window
    logic  mb_zero;
  } dp_status_t;

endpackage

`default_nettype wire

//--- hw/pdp8_sequencer.sv
// ----------------------------------------
// Instruction-cycle FSM with Moore control word. A few
// states also look at mem_finished or mb_zero.
// ----------------------------------------
`timescale 1ns/1ps
`default_nettype none

module pdp8_sequencer
  import pdp8_pkg::*;
(
  input  logic       clock,
  input  logic       resetN,
  input  logic       run,
  input  logic       step,
  input  logic       load_pc,
  input  logic       load_ac,
  input  logic       deposit,
  input  dp_status_t status,
  input  logic       mem_finished,
  output ctrl_t      ctrl,
  output logic       halt,
  output logic       idle
);

  seq_state_t state;
  seq_state_t next_state;
  seq_state_t exec_state;     // Execute entry, held through EA states
  seq_state_t decoded_state;
  opcode_t    opcode;

  assign opcode = status.ir[11:9];

  always_comb begin
    case (opcode)
      OP_AND:         decoded_state = AND_1;
      OP_TAD:         decoded_state = TAD_1;
      OP_ISZ:         decoded_state = ISZ_1;
      OP_DCA:         decoded_state = DCA_1;
      OP_JMS:         decoded_state = JMS_1;
      OP_JMP:         decoded_state = JMP_1;
      OP_IOT, OP_OPR: decoded_state = CPU_IDLE;  // No-ops
      default:        decoded_state = CPU_IDLE;
    endcase
  end

  always_ff @(posedge clock or negedge resetN) begin
    if (!resetN) begin
      state      <= REG_INIT;
      exec_state <= CPU_IDLE;
    end else begin
      state <= next_state;
      if (state == DECODE) begin
        exec_state <= decoded_state;
      end
    end
  end

  always_comb begin
    next_state = state;
    case (state)
      REG_INIT: next_state = CPU_IDLE;
      CPU_IDLE: begin
        if (run || step)  next_state = FETCH_1;
        else if (load_pc) next_state = LD_PC_1;
        else if (load_ac) next_state = LD_AC_1;
        else if (deposit) next_state = DEP_1;
      end
      FETCH_1:  next_state = FETCH_2;
      FETCH_2:  if (mem_finished) next_state = FETCH_3;
      FETCH_3:  next_state = DECODE;
      DECODE: begin
        if (status.ir == HLT_WORD)       next_state = HALT;
        else if (decoded_state == CPU_IDLE) next_state = CPU_IDLE;
        else                             next_state = CAL_EA_1;
      end
      LD_PC_1:  next_state = CPU_IDLE;
      LD_AC_1:  next_state = CPU_IDLE;
      DEP_1:    next_state = DEP_2;
      DEP_2:    if (mem_finished) next_state = CPU_IDLE;
      CAL_EA_1: next_state = status.ir[IR_IND_BIT] ? EA_IND_1 : exec_state;
      EA_IND_1: next_state = status.ea_auto ? EA_AUT_1 : EA_IND_2;
      EA_IND_2: if (mem_finished) next_state = exec_state;
      EA_AUT_1: next_state = EA_AUT_2;
      EA_AUT_2: if (mem_finished) next_state = EA_AUT_3;
      EA_AUT_3: next_state = EA_AUT_4;
      EA_AUT_4: if (mem_finished) next_state = EA_AUT_5;
      EA_AUT_5: next_state = exec_state;
      AND_1:    next_state = AND_2;
      AND_2:    if (mem_finished) next_state = AND_3;
      AND_3:    next_state = CPU_IDLE;
      TAD_1:    next_state = TAD_2;
      TAD_2:    if (mem_finished) next_state = TAD_3;
      TAD_3:    next_state = CPU_IDLE;
      ISZ_1:    next_state = ISZ_2;
      ISZ_2:    if (mem_finished) next_state = ISZ_3;
      ISZ_3:    next_state = ISZ_4;
      ISZ_4:    next_state = ISZ_5;
      ISZ_5:    if (mem_finished) next_state = ISZ_6;
      ISZ_6:    next_state = CPU_IDLE;
      DCA_1:    next_state = DCA_2;
      DCA_2:    if (mem_finished) next_state = DCA_3;
      DCA_3:    next_state = CPU_IDLE;
      JMS_1:    next_state = JMS_2;
      JMS_2:    if (mem_finished) next_state = CPU_IDLE;
      JMP_1:    next_state = CPU_IDLE;
      HALT:     next_state = CPU_IDLE;
      default:  next_state = CPU_IDLE;
    endcase
  end

  always_comb begin
    ctrl.ac_op        = AC_NC;
    ctrl.link_op      = LK_NC;
    ctrl.pc_op        = PC_NC;
    ctrl.ea_op        = EA_NC;
    ctrl.mb_op        = MB_NC;
    ctrl.wd_sel       = WD_NC;
    ctrl.ad_sel       = AD_NC;
    ctrl.ir_load      = 1'b0;
    ctrl.read_enable  = 1'b0;
    ctrl.write_enable = 1'b0;
    halt              = 1'b0;
    idle              = 1'b0;

    case (state)
      REG_INIT: begin
        ctrl.ac_op   = AC_CLEAR;
        ctrl.link_op = LK_ZERO;
        ctrl.ea_op   = EA_ZERO;
        ctrl.mb_op   = MB_ZERO;
      end
      CPU_IDLE: idle = 1'b1;
      FETCH_1:  ctrl.ad_sel = AD_PC;
      FETCH_2: begin
        ctrl.read_enable = 1'b1;
        ctrl.ir_load     = 1'b1;       // Taken on the finished cycle
      end
      FETCH_3:  ctrl.pc_op = PC_P1;
      LD_PC_1:  ctrl.pc_op = PC_SR;
      LD_AC_1:  ctrl.ac_op = AC_SWREG;
      DEP_1: begin
        ctrl.ad_sel = AD_PC;
        ctrl.wd_sel = WD_SR;
      end
      DEP_2: begin
        ctrl.write_enable = 1'b1;
        if (mem_finished) ctrl.pc_op = PC_P1;
      end
      CAL_EA_1: ctrl.ea_op = status.ir[IR_PAGE_BIT] ? EA_CP : EA_PZ;
      EA_IND_1: ctrl.ad_sel = AD_EA;
      EA_IND_2: begin
        ctrl.read_enable = 1'b1;
        if (mem_finished) ctrl.ea_op = EA_IND;
      end
      EA_AUT_1: ctrl.ad_sel = AD_EA;
      EA_AUT_2: ctrl.read_enable = 1'b1;
      EA_AUT_3: ctrl.wd_sel = WD_RDP1;   // Pointer plus one
      EA_AUT_4: ctrl.write_enable = 1'b1;
      EA_AUT_5: ctrl.ea_op = EA_WD;
      AND_1, TAD_1, ISZ_1: ctrl.ad_sel = AD_EA;
      AND_2, TAD_2, ISZ_2: begin
        ctrl.read_enable = 1'b1;
        ctrl.mb_op       = MB_RD;
      end
      AND_3:    ctrl.ac_op = AC_AND;
      TAD_3: begin
        ctrl.ac_op   = AC_TAD;
        ctrl.link_op = LK_TAD;
      end
      ISZ_3:    ctrl.mb_op = MB_INC;
      ISZ_4:    ctrl.wd_sel = WD_MB;
      ISZ_5:    ctrl.write_enable = 1'b1;
      ISZ_6:    if (status.mb_zero) ctrl.pc_op = PC_P1;  // Skip
      DCA_1: begin
        ctrl.ad_sel = AD_EA;
        ctrl.wd_sel = WD_AC;
      end
      DCA_2: begin
        ctrl.write_enable = 1'b1;
        ctrl.mb_op        = MB_WD;
      end
      DCA_3:    ctrl.ac_op = AC_CLEAR;
      JMS_1: begin
        ctrl.ad_sel = AD_EA;
        ctrl.wd_sel = WD_PC;          // Return address
      end
      JMS_2: begin
        ctrl.write_enable = 1'b1;
        ctrl.mb_op        = MB_WD;
        ctrl.pc_op        = PC_EAP1;
      end
      JMP_1:    ctrl.pc_op = PC_EA;
      HALT: begin
        halt = 1'b1;
        idle = 1'b1;
      end
      default: ;
    endcase
  end

endmodule

`default_nettype wire

//--- pdp8_core.f
hw/pdp8_pkg.sv
hw/pdp8_sequencer.sv
hw/pdp8_datapath.sv
hw/pdp8_memory.sv
hw/pdp8_core.sv
bench/tb_clock_gen.sv
bench/pdp8_core_tb.sv
